//--- counter_pkg.sv
/*
 * pulse counter shared definitions
 * channel and pair counts, counter widths, AXI register map and types
 */

package counter_pkg;

	localparam int NUM_CHANNELS = 4;
	localparam int NUM_PAIRS = 2;
	localparam int SAMPLE_WIDTH = 2;
	localparam int COUNT_WIDTH = 12;
	localparam int FRAME_LEN_WIDTH = 16;

	// full range minus largest sample, so the last add never wraps
	localparam int MAX_COUNT = ((1 << COUNT_WIDTH) - 1) - ((1 << SAMPLE_WIDTH) - 1);
	localparam int DIFF_LIMIT = (1 << (COUNT_WIDTH - 1)) - 1;

	typedef logic [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;
	typedef logic signed [COUNT_WIDTH-1:0] diff_t;
	typedef logic [FRAME_LEN_WIDTH-1:0] frame_len_t;
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;

	typedef enum logic [1:0] {
		IDLE,
		RESP,
		DATA
	} axi_state_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ register map ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam axi_addr_t REG_CTRL = 8'h00;
	localparam axi_addr_t REG_FRAME_LEN = 8'h04;
	localparam axi_addr_t REG_FRAME_NUM = 8'h08;
	localparam axi_addr_t REG_COUNT_BASE = 8'h10;
	localparam axi_addr_t REG_DIFF_BASE = 8'h20;
	localparam axi_addr_t REG_OVF = 8'h28;

	localparam int CTRL_RUN_BIT = 0;
	localparam int CTRL_MULTIPLY_BIT = 1;
	localparam frame_len_t FRAME_LEN_DEFAULT = 16'd100;
	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- count_bus.sv
/*
 * count bus
 * running channel totals, pair totals and overflow flags toward the
 * frame latch, frame-end strobe back to the counters
 */

interface count_bus;

	counter_pkg::count_t counts [counter_pkg::NUM_CHANNELS];
	counter_pkg::diff_t diffs [counter_pkg::NUM_PAIRS];
	logic [counter_pkg::NUM_PAIRS-1:0] overflow;
	logic frame_end;

	modport count_src (
		output counts,
		input frame_end
	);

	modport diff_src (
		output diffs,
		output overflow,
		input frame_end
	);

	modport latch (
		output frame_end,
		input counts,
		input diffs,
		input overflow
	);

endinterface

//--- channel_counters.sv
/*
 * channel counters
 * one saturating accumulator per input channel, adding the channel
 * sample on every run cycle and restarting at the frame boundary
 */

module channel_counters (
	input logic clk,
	input logic reset,
	input counter_pkg::sample_t [counter_pkg::NUM_CHANNELS-1:0] samples,
	input logic run,
	count_bus.count_src bus
);

	counter_pkg::count_t sample_ext [counter_pkg::NUM_CHANNELS];

	always_comb begin
		for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
			sample_ext[i] = counter_pkg::count_t'(samples[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
				bus.counts[i] <= '0;
			end
		end else if (run) begin
			for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
				if (bus.frame_end) begin
					// current sample opens the next frame
					bus.counts[i] <= sample_ext[i];
				end else if (bus.counts[i] < counter_pkg::MAX_COUNT) begin
					bus.counts[i] <= bus.counts[i] + sample_ext[i];
				end
			end
		end
	end

endmodule

//--- diff_counters.sv
/*
 * pair counters
 * signed accumulators of the difference or the product of two channels,
 * frozen once the magnitude reaches the overflow bound
 */

module diff_counters (
	input logic clk,
	input logic reset,
	input counter_pkg::sample_t [counter_pkg::NUM_CHANNELS-1:0] samples,
	input logic run,
	input logic multiply,
	count_bus.diff_src bus
);

	counter_pkg::diff_t first [counter_pkg::NUM_PAIRS];
	counter_pkg::diff_t second [counter_pkg::NUM_PAIRS];
	counter_pkg::diff_t contrib [counter_pkg::NUM_PAIRS];
	logic signed [counter_pkg::COUNT_WIDTH:0] sum [counter_pkg::NUM_PAIRS];
	counter_pkg::diff_t next_sum [counter_pkg::NUM_PAIRS];

	always_comb begin
		for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
			first[j] = counter_pkg::diff_t'(samples[2*j]);
			second[j] = counter_pkg::diff_t'(samples[2*j+1]);
			if (multiply) begin
				contrib[j] = first[j] * second[j];
			end else begin
				contrib[j] = first[j] - second[j];
			end
			sum[j] = bus.diffs[j] + contrib[j];

			// clamp at the bound, one extra bit keeps the sum from wrapping
			if (sum[j] > counter_pkg::DIFF_LIMIT) begin
				next_sum[j] = counter_pkg::diff_t'(counter_pkg::DIFF_LIMIT);
			end else if (sum[j] < -counter_pkg::DIFF_LIMIT) begin
				next_sum[j] = counter_pkg::diff_t'(-counter_pkg::DIFF_LIMIT);
			end else begin
				next_sum[j] = counter_pkg::diff_t'(sum[j]);
			end

			bus.overflow[j] = (bus.diffs[j] >= counter_pkg::DIFF_LIMIT) ||
				(bus.diffs[j] <= -counter_pkg::DIFF_LIMIT);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
				bus.diffs[j] <= '0;
			end
		end else if (run) begin
			for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
				if (bus.frame_end) begin
					bus.diffs[j] <= contrib[j];
				end else if (!bus.overflow[j]) begin
					bus.diffs[j] <= next_sum[j];
				end
			end
		end
	end

endmodule

//--- frame_latch.sv
/*
 * frame latch
 * run-cycle frame timer, snapshot of all totals at each frame end,
 * completed frame counter and frame interrupt
 */

module frame_latch (
	input logic clk,
	input logic reset,
	input logic run,
	input counter_pkg::frame_len_t frame_len,
	count_bus.latch bus,
	output counter_pkg::count_t count_snap [counter_pkg::NUM_CHANNELS],
	output counter_pkg::diff_t diff_snap [counter_pkg::NUM_PAIRS],
	output logic [counter_pkg::NUM_PAIRS-1:0] ovf_snap,
	output counter_pkg::axi_data_t frame_num,
	output logic frame_irq
);

	// run cycles counted in the current frame
	counter_pkg::frame_len_t timer;
	logic frame_end;

	// >= so that shortening frame_len mid-frame ends it at once
	assign frame_end = run && (timer >= frame_len);
	assign bus.frame_end = frame_end;
	assign frame_irq = frame_end;

	always_ff @(posedge clk) begin
		if (!reset) begin
			timer <= '0;
			frame_num <= '0;
			ovf_snap <= '0;
			for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
				count_snap[i] <= '0;
			end
			for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
				diff_snap[j] <= '0;
			end
		end else if (run) begin
			if (frame_end) begin
				// this cycle already belongs to the next frame
				timer <= counter_pkg::frame_len_t'(1);
				frame_num <= frame_num + 1'b1;
				ovf_snap <= bus.overflow;
				for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
					count_snap[i] <= bus.counts[i];
				end
				for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
					diff_snap[j] <= bus.diffs[j];
				end
			end else begin
				timer <= timer + 1'b1;
			end
		end
	end

endmodule

//--- axi_lite_regs.sv
/*
 * AXI4-Lite register slave
 * control and frame length registers, read-back of the frame snapshots,
 * separate write and read sequencers with one request in flight each
 */

module axi_lite_regs (
	input logic clk,
	input logic reset,

	input counter_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input counter_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input counter_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output counter_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	output logic run,
	output logic multiply,
	output counter_pkg::frame_len_t frame_len,
	input counter_pkg::count_t count_snap [counter_pkg::NUM_CHANNELS],
	input counter_pkg::diff_t diff_snap [counter_pkg::NUM_PAIRS],
	input logic [counter_pkg::NUM_PAIRS-1:0] ovf_snap,
	input counter_pkg::axi_data_t frame_num
);

	counter_pkg::axi_state_t wr_state;
	counter_pkg::axi_state_t rd_state;
	counter_pkg::axi_data_t read_word;

	assign bresp = counter_pkg::RESP_OKAY;
	assign rresp = counter_pkg::RESP_OKAY;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ write path ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_state <= counter_pkg::IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			run <= 1'b0;
			multiply <= 1'b0;
			frame_len <= counter_pkg::FRAME_LEN_DEFAULT;
		end else begin
			case (wr_state)
				counter_pkg::IDLE: begin
					// address and data must both be present
					if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready <= 1'b1;
						wr_state <= counter_pkg::DATA;
					end
				end
				counter_pkg::DATA: begin
					// write lands on the handshake edge
					awready <= 1'b0;
					wready <= 1'b0;
					bvalid <= 1'b1;
					wr_state <= counter_pkg::RESP;
					if (awaddr == counter_pkg::REG_CTRL && wstrb[0]) begin
						run <= wdata[counter_pkg::CTRL_RUN_BIT];
						multiply <= wdata[counter_pkg::CTRL_MULTIPLY_BIT];
					end
					if (awaddr == counter_pkg::REG_FRAME_LEN) begin
						if (wstrb[0]) begin
							frame_len[7:0] <= wdata[7:0];
						end
						if (wstrb[1]) begin
							frame_len[15:8] <= wdata[15:8];
						end
					end
				end
				counter_pkg::RESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						wr_state <= counter_pkg::IDLE;
					end
				end
				default: wr_state <= counter_pkg::IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ read path ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		read_word = '0;
		case (araddr)
			counter_pkg::REG_CTRL: read_word = {30'd0, multiply, run};
			counter_pkg::REG_FRAME_LEN: read_word = counter_pkg::axi_data_t'(frame_len);
			counter_pkg::REG_FRAME_NUM: read_word = frame_num;
			counter_pkg::REG_OVF: read_word = counter_pkg::axi_data_t'(ovf_snap);
			default: read_word = '0;
		endcase
		for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
			if (araddr == counter_pkg::axi_addr_t'(counter_pkg::REG_COUNT_BASE + 4 * i)) begin
				read_word = counter_pkg::axi_data_t'(count_snap[i]);
			end
		end
		// pair totals sign-extended
		for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
			if (araddr == counter_pkg::axi_addr_t'(counter_pkg::REG_DIFF_BASE + 4 * j)) begin
				read_word = {{(32 - counter_pkg::COUNT_WIDTH){
					diff_snap[j][counter_pkg::COUNT_WIDTH-1]}}, diff_snap[j]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			rd_state <= counter_pkg::IDLE;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			case (rd_state)
				counter_pkg::IDLE: begin
					if (arvalid) begin
						arready <= 1'b1;
						rd_state <= counter_pkg::DATA;
					end
				end
				counter_pkg::DATA: begin
					arready <= 1'b0;
					rvalid <= 1'b1;
					rd_state <= counter_pkg::RESP;
				end
				counter_pkg::RESP: begin
					if (rready) begin
						rvalid <= 1'b0;
						rd_state <= counter_pkg::IDLE;
					end
				end
				default: rd_state <= counter_pkg::IDLE;
			endcase
		end
	end

	// capture the addressed register
	always_ff @(posedge clk) begin
		if (rd_state == counter_pkg::DATA) begin
			rdata <= read_word;
		end
	end

endmodule

//--- pulse_counter_top.sv
/*
 * multi-channel pulse counter
 * channel and pair counters, frame timer with snapshots, AXI4-Lite access
 */

module pulse_counter_top (
	input logic clk,
	input logic reset,

	input counter_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input counter_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input counter_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output counter_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	input counter_pkg::sample_t [counter_pkg::NUM_CHANNELS-1:0] samples,
	output logic frame_irq
);

	logic run;
	logic multiply;
	counter_pkg::frame_len_t frame_len;
	counter_pkg::count_t count_snap [counter_pkg::NUM_CHANNELS];
	counter_pkg::diff_t diff_snap [counter_pkg::NUM_PAIRS];
	logic [counter_pkg::NUM_PAIRS-1:0] ovf_snap;
	counter_pkg::axi_data_t frame_num;

	count_bus u_bus ();

	channel_counters u_channel_counters (
		.clk (clk),
		.reset (reset),
		.samples (samples),
		.run (run),
		.bus (u_bus.count_src)
	);

	diff_counters u_diff_counters (
		.clk (clk),
		.reset (reset),
		.samples (samples),
		.run (run),
		.multiply (multiply),
		.bus (u_bus.diff_src)
	);

	frame_latch u_frame_latch (
		.clk (clk),
		.reset (reset),
		.run (run),
		.frame_len (frame_len),
		.bus (u_bus.latch),
		.count_snap (count_snap),
		.diff_snap (diff_snap),
		.ovf_snap (ovf_snap),
		.frame_num (frame_num),
		.frame_irq (frame_irq)
	);

	axi_lite_regs u_axi_lite_regs (
		.clk (clk),
		.reset (reset),
		.awaddr (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata (wdata),
		.wstrb (wstrb),
		.wvalid (wvalid),
		.wready (wready),
		.bresp (bresp),
		.bvalid (bvalid),
		.bready (bready),
		.araddr (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata (rdata),
		.rresp (rresp),
		.rvalid (rvalid),
		.rready (rready),
		.run (run),
		.multiply (multiply),
		.frame_len (frame_len),
		.count_snap (count_snap),
		.diff_snap (diff_snap),
		.ovf_snap (ovf_snap),
		.frame_num (frame_num)
	);

endmodule

//--- tb_clock.sv
/*
 * testbench clock source, 40-unit period
 */

module tb_clock (
	output logic clk
);

	localparam int PERIOD = 40;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- tb_pulse_counter.sv
/*
 * pulse counter testbench
 * random channel samples, AXI4-Lite register access with back-pressure,
 * per-cycle reference model of the frame totals, snapshot checks
 */

module tb_pulse_counter;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int PAUSE_CYCLES = 300;
	localparam int SHORT_FRAMES = 8;
	localparam int LONG_FRAMES = 2;
	localparam int SAT_FRAMES = 2;
	localparam int WATCHDOG_CYCLES = 2 * (SHORT_FRAMES * 100 + LONG_FRAMES * 400 +
		SAT_FRAMES * 2000 + PAUSE_CYCLES) + 2000;

	logic clk;
	logic reset;
	counter_pkg::axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	counter_pkg::axi_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	counter_pkg::axi_addr_t araddr;
	logic arvalid;
	logic arready;
	counter_pkg::axi_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	counter_pkg::sample_t [counter_pkg::NUM_CHANNELS-1:0] samples;
	logic frame_irq;

	integer seed = 32'h8e7b;
	// 0 random, 1 biased high, 2 all threes
	int sample_mode;

	// reference model state
	bit model_run;
	bit model_mult;
	int model_len = 100;
	int model_timer;
	int irq_count;
	int sum_count [counter_pkg::NUM_CHANNELS];
	int sum_diff [counter_pkg::NUM_PAIRS];
	int exp_count [counter_pkg::NUM_CHANNELS];
	int exp_diff [counter_pkg::NUM_PAIRS];
	bit [counter_pkg::NUM_PAIRS-1:0] exp_ovf;

	tb_clock u_clock (
		.clk (clk)
	);

	pulse_counter_top u_dut (
		.clk (clk),
		.reset (reset),
		.awaddr (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata (wdata),
		.wstrb (wstrb),
		.wvalid (wvalid),
		.wready (wready),
		.bresp (bresp),
		.bvalid (bvalid),
		.bready (bready),
		.araddr (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata (rdata),
		.rresp (rresp),
		.rvalid (rvalid),
		.rready (rready),
		.samples (samples),
		.frame_irq (frame_irq)
	);

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s is 0x%08h, expected 0x%08h", $time, what,
				actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	function automatic int magnitude(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int pair_contrib(input int a, input int b, input bit mult);
		if (mult) begin
			return a * b;
		end
		return a - b;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ reference model ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// evaluated mid-cycle for the coming edge
	task automatic model_step();
		bit exp_irq;
		int a;
		int b;
		exp_irq = model_run && (model_timer >= model_len);
		check_value(32'(frame_irq), 32'(exp_irq), "frame_irq");
		if (frame_irq) begin
			irq_count++;
		end
		if (model_run) begin
			if (exp_irq) begin
				for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
					exp_count[i] = sum_count[i];
					sum_count[i] = 0;
				end
				for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
					exp_diff[j] = sum_diff[j];
					exp_ovf[j] = magnitude(sum_diff[j]) >= counter_pkg::DIFF_LIMIT;
					sum_diff[j] = 0;
				end
				model_timer = 1;
			end else begin
				model_timer++;
			end
			for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
				if (sum_count[i] < counter_pkg::MAX_COUNT) begin
					sum_count[i] += int'(samples[i]);
				end
			end
			for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
				a = int'(samples[2*j]);
				b = int'(samples[2*j+1]);
				if (magnitude(sum_diff[j]) < counter_pkg::DIFF_LIMIT) begin
					sum_diff[j] += pair_contrib(a, b, model_mult);
				end
			end
		end
		// write accepted on the coming edge
		if (awready && wready) begin
			if (awaddr == counter_pkg::REG_CTRL) begin
				model_run = wdata[counter_pkg::CTRL_RUN_BIT];
				model_mult = wdata[counter_pkg::CTRL_MULTIPLY_BIT];
			end
			if (awaddr == counter_pkg::REG_FRAME_LEN) begin
				model_len = int'(wdata[15:0]);
			end
		end
	endtask

	always @(negedge clk) begin
		if (reset) begin
			model_step();
		end
	end

	always @(posedge clk) begin
		#DRIVE_DELAY;
		for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
			case (sample_mode)
				0: samples[i] = counter_pkg::sample_t'($random(seed));
				1: samples[i] = counter_pkg::sample_t'(2 + ($random(seed) & 1));
				default: samples[i] = counter_pkg::sample_t'(3);
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ AXI4-Lite tasks ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic write_reg(input counter_pkg::axi_addr_t addr,
		input counter_pkg::axi_data_t data);
		int delay;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		#DRIVE_DELAY;
		awvalid = 1'b0;
		wvalid = 1'b0;
		// one-cycle ready pulse then the response
		@(negedge clk);
		check_value(32'({awready, wready, bvalid}), 32'b001, "write handshake");
		check_value(32'(bresp), 32'(counter_pkg::RESP_OKAY), "bresp");
		delay = $random(seed) & 3;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		#DRIVE_DELAY;
		bready = 1'b1;
		@(negedge clk);
		check_value(32'(bvalid), 32'd1, "bvalid held until bready");
		@(posedge clk);
		#DRIVE_DELAY;
		bready = 1'b0;
		check_value(32'(bvalid), 32'd0, "bvalid after response");
	endtask

	task automatic read_reg(input counter_pkg::axi_addr_t addr,
		output counter_pkg::axi_data_t data);
		int delay;
		araddr = addr;
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		#DRIVE_DELAY;
		arvalid = 1'b0;
		@(negedge clk);
		check_value(32'({arready, rvalid}), 32'b01, "read handshake");
		data = rdata;
		check_value(32'(rresp), 32'(counter_pkg::RESP_OKAY), "rresp");
		delay = $random(seed) & 3;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		#DRIVE_DELAY;
		rready = 1'b1;
		@(negedge clk);
		check_value(32'(rvalid), 32'd1, "rvalid held until rready");
		check_value(rdata, data, "rdata held until rready");
		@(posedge clk);
		#DRIVE_DELAY;
		rready = 1'b0;
		check_value(32'(rvalid), 32'd0, "rvalid after response");
	endtask

	task automatic wait_frame();
		do @(negedge clk); while (!frame_irq);
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic check_snapshot();
		counter_pkg::axi_data_t value;
		bit at_bound;
		for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
			read_reg(counter_pkg::REG_COUNT_BASE + 8'(4 * i), value);
			check_value(value, exp_count[i], "channel total");
		end
		for (int j = 0; j < counter_pkg::NUM_PAIRS; j++) begin
			read_reg(counter_pkg::REG_DIFF_BASE + 8'(4 * j), value);
			if (magnitude(exp_diff[j]) >= counter_pkg::DIFF_LIMIT) begin
				// frozen pair only has to reach the bound
				at_bound = (exp_diff[j] > 0) ? int'(value) >= counter_pkg::DIFF_LIMIT :
					int'(value) <= -counter_pkg::DIFF_LIMIT;
				check_value(32'(at_bound), 32'd1, "pair total at bound");
			end else begin
				check_value(value, 32'(exp_diff[j]), "pair total");
			end
		end
		read_reg(counter_pkg::REG_OVF, value);
		check_value(value, 32'(exp_ovf), "overflow snapshot");
		read_reg(counter_pkg::REG_FRAME_NUM, value);
		check_value(value, irq_count, "frame number");
	endtask

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("Timeout: the testbench stopped waiting for the DUT to respond");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ test flow ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		counter_pkg::axi_data_t value;
		int len_value;
		int frames_before;
		reset = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		samples = '0;
		sample_mode = 0;
		len_value = 50 + ($random(seed) & 255);
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		check_value(32'({awready, wready, bvalid, arready, rvalid, frame_irq}), 32'd0,
			"outputs after reset");

		// register access
		check_snapshot();
		write_reg(counter_pkg::REG_FRAME_LEN, len_value);
		read_reg(counter_pkg::REG_FRAME_LEN, value);
		check_value(value, len_value, "frame length readback");
		write_reg(counter_pkg::REG_CTRL, 32'd2);
		read_reg(counter_pkg::REG_CTRL, value);
		check_value(value, 32'd2, "control readback");
		read_reg(8'h0c, value);
		check_value(value, 32'd0, "unmapped read");
		for (int k = 0; k < 4; k++) begin
			read_reg(8'h2c + 8'(4 * k), value);
			check_value(value, 32'd0, "unmapped read");
		end
		write_reg(counter_pkg::REG_FRAME_LEN, 32'd100);
		write_reg(counter_pkg::REG_CTRL, 32'd0);

		// channel totals, difference mode
		write_reg(counter_pkg::REG_CTRL, 32'd1);
		repeat (3) begin
			wait_frame();
			check_snapshot();
		end

		// product mode, then biased samples up to the bound
		write_reg(counter_pkg::REG_CTRL, 32'd3);
		repeat (3) begin
			wait_frame();
			check_snapshot();
		end
		sample_mode = 1;
		write_reg(counter_pkg::REG_FRAME_LEN, 32'd400);
		repeat (LONG_FRAMES) begin
			wait_frame();
			check_snapshot();
		end
		read_reg(counter_pkg::REG_OVF, value);
		check_value(value, 32'd3, "overflow bits in product mode");

		// saturation
		sample_mode = 2;
		write_reg(counter_pkg::REG_CTRL, 32'd1);
		write_reg(counter_pkg::REG_FRAME_LEN, 32'd2000);
		repeat (SAT_FRAMES) begin
			wait_frame();
			check_snapshot();
		end
		for (int i = 0; i < counter_pkg::NUM_CHANNELS; i++) begin
			read_reg(counter_pkg::REG_COUNT_BASE + 8'(4 * i), value);
			check_value(32'(value >= counter_pkg::MAX_COUNT), 32'd1, "saturated total");
		end

		// pause holds the counters and the timer
		sample_mode = 0;
		write_reg(counter_pkg::REG_CTRL, 32'd0);
		frames_before = irq_count;
		repeat (PAUSE_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		check_value(irq_count, frames_before, "frame_irq count while paused");
		check_snapshot();
		write_reg(counter_pkg::REG_FRAME_LEN, 32'd100);
		write_reg(counter_pkg::REG_CTRL, 32'd1);
		repeat (2) begin
			wait_frame();
			check_snapshot();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- pulse_counter.f
counter_pkg.sv
count_bus.sv
channel_counters.sv
diff_counters.sv
frame_latch.sv
axi_lite_regs.sv
pulse_counter_top.sv
tb_clock.sv
tb_pulse_counter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pulse counter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pulse_counter \
	-f pulse_counter.f || { echo "build failed"; exit 1; }

sim_output=$(./obj_dir/Vtb_pulse_counter 2>&1)
echo "$sim_output"
echo "$sim_output" | grep -q "Simulation finished: PASS" && exit 0 || exit 1
